//--- verif/fifo_stimulus.txt
# kind cycles push_pct pop_pct exp_slots exp_items exp_full
# exp fields of -1 are not checked; for drain the cycle count is the timeout
fill 6 100 0 0 4 1
drain 12 0 100 4 0 0
bypass 8 100 100 4 0 0
random 200 60 50 -1 -1 -1
random 200 90 20 -1 -1 -1
drain 12 0 100 4 0 0
fill 8 100 0 0 4 1
random 300 50 50 -1 -1 -1
drain 12 0 100 4 0 0
bypass 12 70 100 4 0 0
random 250 30 80 -1 -1 -1
random 250 95 60 -1 -1 -1
drain 12 0 100 4 0 0
fill 5 100 0 0 4 1
random 150 40 40 -1 -1 -1
drain 12 0 100 4 0 0
bypass 6 50 100 4 0 0
random 300 75 75 -1 -1 -1
random 100 100 10 -1 -1 -1
drain 12 0 100 4 0 0
fill 4 100 0 1 3 0
drain 12 0 100 4 0 0
bypass 10 100 100 4 0 0

//--- filelist.f
hw/fifo_data_pkg.sv
hw/fifo_status_pkg.sv
hw/fifo_ram.sv
hw/fifo_push_ctrl.sv
hw/fifo_pop_ctrl.sv
hw/fifo_top.sv
verif/fifo_tb.sv

//--- verif/fifo_tb.sv
// FIFO testbench
// Drives fifo_top from a phase file, keeps a queue model of the
// contents and checks flags, counts and popped words every cycle

`timescale 1ns/1ns
`default_nettype none

module fifo_tb;

  localparam int DEPTH = fifo_status_pkg::DEF_DEPTH;

  logic                      clk;
  logic                      rst_n;
  logic                      push_valid;
  fifo_data_pkg::data_t      push_data;
  logic                      push_ready;
  logic                      pop_ready;
  logic                      pop_valid;
  fifo_data_pkg::data_t      pop_data;
  logic                      full;
  fifo_status_pkg::count_t   slots;
  logic                      empty;
  fifo_status_pkg::count_t   items;

  // Model of the stored words, head at index 0
  fifo_data_pkg::data_t      model_q[$];
  integer                    seed;
  bit                        recover_due;
  int                        pop_count;

  fifo_top #(
    .Depth(fifo_status_pkg::DEF_DEPTH),
    .BitWidth(fifo_data_pkg::DEF_BIT_WIDTH),
    .EnableBypass(fifo_status_pkg::DEF_ENABLE_BYPASS)
  ) dut0 (
    .clk, .rst_n, .push_valid, .push_data, .push_ready,
    .pop_ready, .pop_valid, .pop_data, .full, .slots, .empty, .items
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // --------------------
  // Failure and compares
  // --------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input fifo_data_pkg::data_t got,
                            input fifo_data_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("data mismatch");
    end
  endtask

  task automatic check_count(input string name, input fifo_status_pkg::count_t got,
                             input fifo_status_pkg::count_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("count mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("flag mismatch");
    end
  endtask

  // --------------------
  // One clock cycle
  // --------------------

  // Drive at the rising edge, check at the falling edge
  task automatic step_cycle(input bit push_en, input bit pop_en);
    fifo_data_pkg::data_t word;
    int used;
    bit push_acc;
    bit pop_acc;
    word = fifo_data_pkg::data_t'($random(seed));
    @(posedge clk);
    push_valid <= push_en;
    push_data  <= word;
    pop_ready  <= pop_en;
    @(negedge clk);
    used = model_q.size();
    // One pop while full frees the push side right away
    if (recover_due) begin
      check_flag("push_ready", push_ready, 1'b1);
    end
    check_count("items", items, fifo_status_pkg::count_t'(used));
    check_count("slots", slots, fifo_status_pkg::count_t'(DEPTH - used));
    check_count("items+slots", fifo_status_pkg::count_t'(items + slots),
                fifo_status_pkg::count_t'(DEPTH));
    check_flag("full", full, used == DEPTH);
    check_flag("empty", empty, used == 0);
    check_flag("push_ready", push_ready, used != DEPTH);
    if (used > 0) begin
      check_flag("pop_valid", pop_valid, 1'b1);
      check_data("pop_data", pop_data, model_q[0]);
    end else begin
      // Empty store, so the push word shows up through the bypass
      check_flag("pop_valid", pop_valid, push_valid);
      if (push_valid) begin
        check_data("pop_data", pop_data, push_data);
      end
    end
    push_acc = push_valid && push_ready;
    pop_acc  = pop_valid && pop_ready;
    recover_due = pop_acc && full;
    // Push before pop so a bypassed word passes through the model
    if (push_acc) begin
      model_q.push_back(push_data);
    end
    if (pop_acc) begin
      void'(model_q.pop_front());
      pop_count++;
    end
  endtask

  // --------------------
  // Phases
  // --------------------

  task automatic drain_until_empty(input int limit);
    int waited;
    waited = 0;
    while (!(empty && model_q.size() == 0 && !push_valid)) begin
      if (waited >= limit) begin
        abort_run("timeout while draining the FIFO to empty");
      end
      step_cycle(1'b0, 1'b1);
      waited++;
    end
    check_flag("pop_valid", pop_valid, 1'b0);
  endtask

  task automatic play_phase(input logic [8*16-1:0] kind, input int cycles,
                            input int push_pct, input int pop_pct);
    bit push_en;
    bit pop_en;
    if (kind == "drain") begin
      drain_until_empty(cycles);
    end else if (kind == "fill" || kind == "bypass" || kind == "random") begin
      if (kind != "random" && model_q.size() != 0) begin
        abort_run("fill or bypass phase started with words still stored");
      end
      for (int i = 0; i < cycles; i++) begin
        push_en = ({$random(seed)} % 100) < push_pct;
        pop_en  = ({$random(seed)} % 100) < pop_pct;
        step_cycle(push_en, pop_en);
      end
    end else begin
      abort_run("unknown phase kind in the stimulus file");
    end
  endtask

  // Expected status from the file
  // A field of -1 is skipped
  task automatic compare_phase_end(input int exp_slots, input int exp_items,
                                   input int exp_full);
    if (exp_slots >= 0) begin
      check_count("slots", slots, fifo_status_pkg::count_t'(exp_slots));
    end
    if (exp_items >= 0) begin
      check_count("items", items, fifo_status_pkg::count_t'(exp_items));
    end
    if (exp_full >= 0) begin
      check_flag("full", full, exp_full != 0);
      check_flag("push_ready", push_ready, exp_full == 0);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int fd;
    int status;
    int n;
    int phases;
    int cycles;
    int push_pct;
    int pop_pct;
    int exp_slots;
    int exp_items;
    int exp_full;
    logic [8*160-1:0] line_buf;
    logic [8*16-1:0]  kind;
    seed        = 32'h7a24_7751;
    clk         = 1'b0;
    rst_n       = 1'b0;
    push_valid  = 1'b0;
    push_data   = '0;
    pop_ready   = 1'b0;
    recover_due = 1'b0;
    pop_count   = 0;
    phases      = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // Reset state
    check_count("slots", slots, fifo_status_pkg::count_t'(DEPTH));
    check_count("items", items, '0);
    check_flag("full", full, 1'b0);
    check_flag("empty", empty, 1'b1);
    check_flag("push_ready", push_ready, 1'b1);
    check_flag("pop_valid", pop_valid, 1'b0);
    fd = $fopen("verif/fifo_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verif/fifo_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line_buf = '0;
      kind = '0;
      status = $fgets(line_buf, fd);
      if (status != 0) begin
        n = $sscanf(line_buf, "%s %d %d %d %d %d %d", kind, cycles, push_pct,
                    pop_pct, exp_slots, exp_items, exp_full);
        if (n == 7) begin
          play_phase(kind, cycles, push_pct, pop_pct);
          compare_phase_end(exp_slots, exp_items, exp_full);
          phases++;
        end else if (n >= 1 && kind != "#") begin
          abort_run("malformed line in the stimulus file");
        end
      end
    end
    $fclose(fd);
    if (phases == 0 || pop_count == 0) begin
      abort_run("stimulus file ran no phase that moved data");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule : fifo_tb

`default_nettype wire

//--- hw/fifo_top.sv
// FIFO top level
// Single-clock ready/valid FIFO built from a push controller, a
// register-array store and a pop controller, with optional bypass

`timescale 1ns/1ns
`default_nettype none

module fifo_top #(
  parameter int Depth = fifo_status_pkg::DEF_DEPTH,
  parameter int BitWidth = fifo_data_pkg::DEF_BIT_WIDTH,
  parameter bit EnableBypass = fifo_status_pkg::DEF_ENABLE_BYPASS,
  localparam int AddrWidth = fifo_status_pkg::addr_width(Depth),
  localparam int CountWidth = fifo_status_pkg::count_width(Depth)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Push port
  input  logic                  push_valid,
  input  logic [BitWidth-1:0]   push_data,
  output logic                  push_ready,
  // Pop port
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output logic [BitWidth-1:0]   pop_data,
  // Status
  output logic                  full,
  output logic [CountWidth-1:0] slots,
  output logic                  empty,
  output logic [CountWidth-1:0] items
);

  // --------------------
  // Internal wires
  // --------------------

  logic                 ram_wr_valid;
  logic [AddrWidth-1:0] ram_wr_addr;
  logic [BitWidth-1:0]  ram_wr_data;
  logic [AddrWidth-1:0] ram_rd_addr;
  logic [BitWidth-1:0]  ram_rd_data;
  logic                 ram_push;
  logic                 ram_pop;
  logic                 bypass_valid;
  logic [BitWidth-1:0]  bypass_data;
  logic                 bypass_ready;

  // Push stage
  fifo_push_ctrl #(
    .Depth(Depth),
    .BitWidth(BitWidth),
    .EnableBypass(EnableBypass)
  ) push_ctrl0 (
    .clk, .rst_n, .push_valid, .push_data, .push_ready, .full, .slots,
    .bypass_ready, .bypass_valid, .bypass_data,
    .ram_wr_valid, .ram_wr_addr, .ram_wr_data, .ram_push, .ram_pop
  );

  // Storage
  fifo_ram #(
    .Depth(Depth),
    .BitWidth(BitWidth)
  ) ram0 (
    .clk, .ram_wr_valid, .ram_wr_addr, .ram_wr_data, .ram_rd_addr, .ram_rd_data
  );

  // Pop stage
  fifo_pop_ctrl #(
    .Depth(Depth),
    .BitWidth(BitWidth),
    .EnableBypass(EnableBypass)
  ) pop_ctrl0 (
    .clk, .rst_n, .pop_ready, .pop_valid, .pop_data, .empty, .items,
    .bypass_valid, .bypass_data, .bypass_ready,
    .ram_rd_addr, .ram_rd_data, .ram_push, .ram_pop
  );

endmodule : fifo_top

`default_nettype wire

//--- hw/fifo_pop_ctrl.sv
// FIFO pop controller
// Ready/valid pop side: keeps the item count and empty flag, reads
// storage at its own address, and falls back to the bypass word
// while storage is empty

`timescale 1ns/1ns
`default_nettype none

module fifo_pop_ctrl #(
  parameter int Depth = 2,
  parameter int BitWidth = 1,
  parameter bit EnableBypass = 1'b1,
  localparam int AddrWidth = fifo_status_pkg::addr_width(Depth),
  localparam int CountWidth = fifo_status_pkg::count_width(Depth)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Pop port
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output logic [BitWidth-1:0]   pop_data,
  // Status
  output logic                  empty,
  output logic [CountWidth-1:0] items,
  // Bypass from the push stage
  input  logic                  bypass_valid,
  input  logic [BitWidth-1:0]   bypass_data,
  output logic                  bypass_ready,
  // Storage read port
  output logic [AddrWidth-1:0]  ram_rd_addr,
  input  logic [BitWidth-1:0]   ram_rd_data,
  // Handshakes with the push stage
  input  logic                  ram_push,
  output logic                  ram_pop
);

  logic                  use_bypass;
  logic [CountWidth-1:0] items_next;
  logic                  empty_next;

  // --------------------
  // Output select
  // --------------------

  // Bypass only when nothing is stored, so order is kept
  assign use_bypass = EnableBypass && empty;

  assign pop_valid = use_bypass ? bypass_valid : !empty;
  assign pop_data  = use_bypass ? bypass_data : ram_rd_data;

  // Pushed word goes straight out in this cycle
  assign bypass_ready = use_bypass && pop_ready;

  // Taken pop from storage
  assign ram_pop = !empty && pop_ready;

  // --------------------
  // Read address
  // --------------------

  // Same wrap rule as the write side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_rd_addr <= '0;
    end else if (ram_pop) begin
      if (ram_rd_addr == AddrWidth'(Depth - 1)) begin
        ram_rd_addr <= '0;
      end else begin
        ram_rd_addr <= ram_rd_addr + 1'b1;
      end
    end
  end

  // --------------------
  // Items and empty
  // --------------------

  // Mirror image of the slot count
  assign items_next = (ram_push && !ram_pop) ? items + 1'b1 :
                      (!ram_push && ram_pop) ? items - 1'b1 : items;
  assign empty_next = (items_next == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else if (ram_push || ram_pop) begin
      items <= items_next;
      empty <= empty_next;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Count never runs past the array
  a_items_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    items <= CountWidth'(Depth));

  // No read from an empty store
  a_pop_needs_items: assert property (@(posedge clk) disable iff (!rst_n)
    ram_pop |-> items != '0);

  // Stalled storage word holds; writes never land on the head entry
  a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready && !empty |=> pop_valid && $stable(pop_data));

endmodule : fifo_pop_ctrl

`default_nettype wire

//--- hw/fifo_push_ctrl.sv
// FIFO push controller
// Ready/valid push side: accepts words while not full, sends each one
// to storage or across the bypass, and keeps the free-slot count and
// the full flag

`timescale 1ns/1ns
`default_nettype none

module fifo_push_ctrl #(
  parameter int Depth = 2,
  parameter int BitWidth = 1,
  parameter bit EnableBypass = 1'b1,
  localparam int AddrWidth = fifo_status_pkg::addr_width(Depth),
  localparam int CountWidth = fifo_status_pkg::count_width(Depth)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Push port
  input  logic                  push_valid,
  input  logic [BitWidth-1:0]   push_data,
  output logic                  push_ready,
  // Status
  output logic                  full,
  output logic [CountWidth-1:0] slots,
  // Bypass toward the pop stage
  input  logic                  bypass_ready,
  output logic                  bypass_valid,
  output logic [BitWidth-1:0]   bypass_data,
  // Storage write port
  output logic                  ram_wr_valid,
  output logic [AddrWidth-1:0]  ram_wr_addr,
  output logic [BitWidth-1:0]   ram_wr_data,
  // Handshakes with the pop stage
  output logic                  ram_push,
  input  logic                  ram_pop
);

  // --------------------
  // Flow control
  // --------------------

  logic                  push;
  logic                  bypass_taken;
  logic [CountWidth-1:0] slots_next;
  logic                  full_next;

  // Back-pressure only on full
  assign push_ready = !full;
  assign push       = push_valid && push_ready;

  // Bypass path mirrors the push port when enabled
  assign bypass_valid = EnableBypass ? push_valid : 1'b0;
  assign bypass_data  = EnableBypass ? push_data : '0;
  assign bypass_taken = EnableBypass && bypass_ready;

  // Word goes to storage unless the pop side takes it directly
  assign ram_push     = push && !bypass_taken;
  assign ram_wr_valid = ram_push;
  assign ram_wr_data  = push_data;

  // --------------------
  // Write address
  // --------------------

  // Wraps after the last entry, so non power-of-two depths work too
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_wr_addr <= '0;
    end else if (ram_wr_valid) begin
      if (ram_wr_addr == AddrWidth'(Depth - 1)) begin
        ram_wr_addr <= '0;
      end else begin
        ram_wr_addr <= ram_wr_addr + 1'b1;
      end
    end
  end

  // --------------------
  // Slots and full
  // --------------------

  // Push and pop in the same cycle cancel out
  assign slots_next = (ram_push && !ram_pop) ? slots - 1'b1 :
                      (!ram_push && ram_pop) ? slots + 1'b1 : slots;
  assign full_next  = (slots_next == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= CountWidth'(Depth);
      full  <= 1'b0;
    end else if (ram_push || ram_pop) begin
      slots <= slots_next;
      full  <= full_next;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Pop side cannot read from an empty store
  a_no_pop_when_all_slots: assert property (@(posedge clk) disable iff (!rst_n)
    slots == CountWidth'(Depth) |-> !ram_pop);

  // Pop side only offers bypass when storage holds nothing
  a_bypass_ready_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    bypass_ready |-> !full);

  // A bypassed word never touches storage or the slot count
  a_push_bypass_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    push && bypass_taken |=> $stable(slots));

  // One-cycle back-pressure recovery
  a_full_recovers: assert property (@(posedge clk) disable iff (!rst_n)
    full && ram_pop |=> !full && push_ready);

endmodule : fifo_push_ctrl

`default_nettype wire

//--- hw/fifo_ram.sv
// FIFO storage
// Register array of Depth words, one synchronous write port and one
// combinational read port, no reset on the contents

`timescale 1ns/1ns
`default_nettype none

module fifo_ram #(
  parameter int Depth = 2,
  parameter int BitWidth = 1,
  localparam int AddrWidth = fifo_status_pkg::addr_width(Depth)
) (
  input  logic                 clk,
  // Write port
  input  logic                 ram_wr_valid,
  input  logic [AddrWidth-1:0] ram_wr_addr,
  input  logic [BitWidth-1:0]  ram_wr_data,
  // Read port
  input  logic [AddrWidth-1:0] ram_rd_addr,
  output logic [BitWidth-1:0]  ram_rd_data
);

  // --------------------
  // Storage array
  // --------------------

  logic [BitWidth-1:0] mem [Depth];

  // Write at the accepting edge
  always_ff @(posedge clk) begin
    if (ram_wr_valid) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  // Read is a plain mux, visible in the same cycle
  assign ram_rd_data = mem[ram_rd_addr];

  // --------------------
  // Checks
  // --------------------

  // Push counter wrap must stay inside the array
  a_wr_addr_in_range: assert property (@(posedge clk)
    ram_wr_valid |-> ram_wr_addr < Depth);

endmodule : fifo_ram

`default_nettype wire

//--- hw/fifo_status_pkg.sv
// FIFO status package
// Default depth and bypass enable, plus the width helpers and the
// count type used by the slot and item counters

`default_nettype none

package fifo_status_pkg;

  // Default number of storage entries
  parameter int DEF_DEPTH = 4;

  // Bypass on by default
  parameter bit DEF_ENABLE_BYPASS = 1'b1;

  // Width that holds 0..depth inclusive
  function automatic int count_width(int depth);
    return $clog2(depth + 1);
  endfunction

  // Width of an entry index, at least one bit
  function automatic int addr_width(int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

  // Slot or item count at the default depth
  typedef logic [count_width(DEF_DEPTH)-1:0] count_t;

endpackage : fifo_status_pkg

`default_nettype wire

//--- hw/fifo_data_pkg.sv
// FIFO data package
// Default word width and the word type shared by the top-level
// defaults and the testbench compare tasks

`default_nettype none

package fifo_data_pkg;

  // --------------------
  // Word width
  // --------------------

  // Default width of one FIFO word in bits
  parameter int DEF_BIT_WIDTH = 8;

  // --------------------
  // Word type
  // --------------------

  // One word as it travels through push, storage and pop
  typedef logic [DEF_BIT_WIDTH-1:0] data_t;

endpackage : fifo_data_pkg

`default_nettype wire
